// ==== include/router_config.svh ====
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// Queue geometry
`define ROUTER_QUEUES 4
`define ROUTER_SLOTS 6

// Consecutive start cycles to arm the receiver
`define ROUTER_START_HOLD 3

// Per-queue drop counter that wraps
`define ROUTER_DROP_W 8

// Total drop counter that wraps
`define ROUTER_TOTAL_W 10

`endif

// ==== source/router_pkg.sv ====
`include "router_config.svh"

package router_pkg;

	// Four-bit packet with dest received first
	typedef struct packed {
		logic [1:0] dest;	// Queue select
		logic [1:0] payload;
	} packet_t;

	// 7 marks an empty slot and 0 to 3 a stored payload
	typedef logic [2:0] slot_t;

	// Slot 0 holds the newest entry
	typedef slot_t [`ROUTER_SLOTS-1:0] slot_vec_t;

	// Everything visible about one queue
	typedef struct packed {
		slot_vec_t                 slots;
		logic [2:0]                occupancy;	// Occupied slots
		logic [`ROUTER_DROP_W-1:0] drops;
	} queue_view_t;

endpackage

// ==== source/symbol_receiver.sv ====
`timescale 1ns/1ps
`include "router_config.svh"

module symbol_receiver import router_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	input  logic    bin0,
	input  logic    bin1,
	output logic    armed,
	output packet_t pkt,
	output logic    pkt_valid
);

	localparam int HOLD_W = $clog2(`ROUTER_START_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt;	// Consecutive start cycles
	logic              sep_seen;
	logic [1:0]        bit_idx;
	logic [2:0]        shift_reg;	// Bits received so far
	logic [1:0]        symbol;
	logic              bit_valid;
	logic              bit_value;

	assign symbol = {bin1, bin0};

	// 10 is bit 0 and 01 is bit 1 when a separator came first
	always_comb begin
		case (symbol)
			2'b10: begin
				bit_valid = sep_seen;
				bit_value = 1'b0;
			end
			2'b01: begin
				bit_valid = sep_seen;
				bit_value = 1'b1;
			end
			default: begin
				bit_valid = 1'b0;
				bit_value = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hold_cnt  <= '0;
			armed     <= 1'b0;
			sep_seen  <= 1'b0;
			bit_idx   <= 2'd0;
			pkt_valid <= 1'b0;
		end else begin
			pkt_valid <= 1'b0;
			if (!armed) begin
				if (start) begin
					if (hold_cnt == HOLD_W'(`ROUTER_START_HOLD - 1)) begin
						hold_cnt <= '0;
						armed    <= 1'b1;
						sep_seen <= 1'b1;	// Arming counts as a separator
						bit_idx  <= 2'd0;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end else begin
					hold_cnt <= '0;	// Run broken
				end
			end else if (symbol == 2'b11) begin
				sep_seen <= 1'b1;
			end else if (bit_valid) begin
				sep_seen <= 1'b0;
				bit_idx  <= bit_idx + 2'd1;
				if (bit_idx == 2'd3) begin
					pkt_valid <= 1'b1;
					armed     <= 1'b0;	// Next packet needs a new arming
				end
			end
		end
	end

	// Packet assembly with MSB first
	always_ff @(posedge clk) begin
		if (armed && bit_valid) begin
			shift_reg <= {shift_reg[1:0], bit_value};
			if (bit_idx == 2'd3)
				pkt <= {shift_reg, bit_value};
		end
	end

	assert property (@(posedge clk) disable iff (reset) pkt_valid |=> !pkt_valid)
		else $error("pkt_valid high on two consecutive cycles");

endmodule

// ==== source/slot_buffer.sv ====
`timescale 1ns/1ps
`include "router_config.svh"

module slot_buffer import router_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  logic [1:0] payload,
	output slot_vec_t  slots,
	output logic [2:0] occupancy,
	output logic       overflow
);

	localparam slot_t EMPTY = 3'd7;

	// Shift history where the oldest entry falls off the top
	always_ff @(posedge clk) begin
		if (reset) begin
			slots    <= {`ROUTER_SLOTS{EMPTY}};
			overflow <= 1'b0;
		end else begin
			overflow <= 1'b0;
			if (push) begin
				slots    <= {slots[`ROUTER_SLOTS-2:0], {1'b0, payload}};
				overflow <= ~slots[`ROUTER_SLOTS-1][2];	// Lost an occupied entry
			end
		end
	end

	// Occupied slots have the top bit clear
	always_comb begin
		occupancy = 3'd0;
		for (int i = 0; i < `ROUTER_SLOTS; i++) begin
			if (!slots[i][2])
				occupancy = occupancy + 3'd1;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		occupancy <= 3'(`ROUTER_SLOTS))
		else $error("occupancy %0d above slot count", occupancy);

endmodule

// ==== source/queue_bank.sv ====
`timescale 1ns/1ps
`include "router_config.svh"

module queue_bank import router_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  packet_t                   pkt,
	input  logic                      pkt_valid,
	output slot_vec_t                 slots     [`ROUTER_QUEUES],
	output logic [2:0]                occupancy [`ROUTER_QUEUES],
	output logic [`ROUTER_QUEUES-1:0] overflow
);

	logic [`ROUTER_QUEUES-1:0] push;	// One-hot queue select

	genvar q;
	generate
		for (q = 0; q < `ROUTER_QUEUES; q++) begin : g_queue
			assign push[q] = pkt_valid && (pkt.dest == 2'(q));

			slot_buffer slot_buffer_i (
				.clk       (clk),
				.reset     (reset),
				.push      (push[q]),
				.payload   (pkt.payload),
				.slots     (slots[q]),
				.occupancy (occupancy[q]),
				.overflow  (overflow[q])
			);
		end
	endgenerate

	assert property (@(posedge clk) disable iff (reset) $onehot0(push))
		else $error("more than one queue pushed, push = %b", push);

endmodule

// ==== source/drop_stats.sv ====
`timescale 1ns/1ps
`include "router_config.svh"

module drop_stats (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`ROUTER_QUEUES-1:0]  overflow,
	output logic [`ROUTER_DROP_W-1:0]  drops [`ROUTER_QUEUES],
	output logic [`ROUTER_TOTAL_W-1:0] drop_total
);

	localparam int HIT_W = $clog2(`ROUTER_QUEUES + 1);

	logic [HIT_W-1:0] hit_count;	// Pulses this cycle

	always_comb begin
		hit_count = '0;
		for (int q = 0; q < `ROUTER_QUEUES; q++) begin
			if (overflow[q])
				hit_count = hit_count + 1'b1;
		end
	end

	// Per-queue counters
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int q = 0; q < `ROUTER_QUEUES; q++)
				drops[q] <= '0;
		end else begin
			for (int q = 0; q < `ROUTER_QUEUES; q++) begin
				if (overflow[q])
					drops[q] <= drops[q] + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			drop_total <= '0;
		else
			drop_total <= drop_total + `ROUTER_TOTAL_W'(hit_count);
	end

endmodule

// ==== source/packet_router_top.sv ====
`timescale 1ns/1ps
`include "router_config.svh"

module packet_router_top import router_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  logic                       bin0,
	input  logic                       bin1,
	output logic                       armed,
	output packet_t                    pkt,
	output logic                       pkt_valid,
	output queue_view_t                queues [`ROUTER_QUEUES],
	output logic [`ROUTER_TOTAL_W-1:0] drop_total
);

	slot_vec_t                 q_slots     [`ROUTER_QUEUES];
	logic [2:0]                q_occupancy [`ROUTER_QUEUES];
	logic [`ROUTER_DROP_W-1:0] q_drops     [`ROUTER_QUEUES];
	logic [`ROUTER_QUEUES-1:0] q_overflow;

	symbol_receiver symbol_receiver_i (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.bin0      (bin0),
		.bin1      (bin1),
		.armed     (armed),
		.pkt       (pkt),
		.pkt_valid (pkt_valid)
	);

	queue_bank queue_bank_i (
		.clk       (clk),
		.reset     (reset),
		.pkt       (pkt),
		.pkt_valid (pkt_valid),
		.slots     (q_slots),
		.occupancy (q_occupancy),
		.overflow  (q_overflow)
	);

	drop_stats drop_stats_i (
		.clk        (clk),
		.reset      (reset),
		.overflow   (q_overflow),
		.drops      (q_drops),
		.drop_total (drop_total)
	);

	// One view per queue
	genvar q;
	generate
		for (q = 0; q < `ROUTER_QUEUES; q++) begin : g_view
			assign queues[q] = '{slots: q_slots[q], occupancy: q_occupancy[q], drops: q_drops[q]};
		end
	endgenerate

endmodule

// ==== tb/tb_packet_router.sv ====
`timescale 1ns/1ps
`include "router_config.svh"

module tb_packet_router import router_pkg::*; ();

	localparam int TOTAL_PACKETS  = 56;
	localparam int TIMEOUT_CYCLES = TOTAL_PACKETS * 40 + 500;
	localparam slot_t EMPTY = 3'd7;

	typedef struct packed {
		queue_view_t [`ROUTER_QUEUES-1:0] q;
		logic [`ROUTER_TOTAL_W-1:0]       total;
	} model_t;

	logic                       clk;
	logic                       reset;
	logic                       start;
	logic                       bin0;
	logic                       bin1;
	logic                       armed;
	packet_t                    pkt;
	logic                       pkt_valid;
	queue_view_t                queues [`ROUTER_QUEUES];
	logic [`ROUTER_TOTAL_W-1:0] drop_total;

	model_t      model;
	packet_t     sent_q [$];	// Sent packets awaiting pkt_valid
	packet_t     exp_pkt;
	int          sent_total;
	int          checked_count;
	string       test_name;
	integer      seed;
	logic [31:0] rnd;

	packet_router_top packet_router_top_i (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.bin0       (bin0),
		.bin1       (bin1),
		.armed      (armed),
		.pkt        (pkt),
		.pkt_valid  (pkt_valid),
		.queues     (queues),
		.drop_total (drop_total)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$fatal(1);
	end

	function automatic model_t init_model();
		model_t      m;
		queue_view_t v;
		for (int q = 0; q < `ROUTER_QUEUES; q++) begin
			for (int i = 0; i < `ROUTER_SLOTS; i++)
				v.slots[i] = EMPTY;
			v.occupancy = 3'd0;
			v.drops     = '0;
			m.q[q]      = v;
		end
		m.total = '0;
		return m;
	endfunction

	// Expected state after one packet enters its queue
	function automatic model_t apply_packet(model_t m, packet_t p);
		queue_view_t v;
		slot_t       oldest;
		v      = m.q[p.dest];
		oldest = v.slots[`ROUTER_SLOTS-1];
		for (int i = `ROUTER_SLOTS-1; i > 0; i--)
			v.slots[i] = v.slots[i-1];
		v.slots[0] = {1'b0, p.payload};
		if (oldest != EMPTY) begin
			v.drops = v.drops + 1'b1;
			m.total = m.total + 1'b1;
		end else begin
			v.occupancy = v.occupancy + 3'd1;	// Queue not full yet
		end
		m.q[p.dest] = v;
		return m;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) step();
	endtask

	task automatic stop_failed();
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		stop_failed();
	endtask

	task automatic check(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: test %s, %s expected %0h actual %0h",
				test_name, what, expected, actual);
			stop_failed();
		end
	endtask

	task automatic compare_model();
		for (int q = 0; q < `ROUTER_QUEUES; q++) begin
			for (int i = 0; i < `ROUTER_SLOTS; i++)
				check($sformatf("queue %0d slot %0d", q, i),
					32'(model.q[q].slots[i]), 32'(queues[q].slots[i]));
			check($sformatf("queue %0d occupancy", q),
				32'(model.q[q].occupancy), 32'(queues[q].occupancy));
			check($sformatf("queue %0d drops", q),
				32'(model.q[q].drops), 32'(queues[q].drops));
		end
		check("drop_total", 32'(model.total), 32'(drop_total));
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		idle(4);
		reset = 1'b0;
		model = init_model();
	endtask

	task automatic hold_start(input int cycles);
		start = 1'b1;
		idle(cycles);
		start = 1'b0;
	endtask

	task automatic send_symbol(input logic b1, input logic b0);
		bin1 = b1;
		bin0 = b0;
		step();
	endtask

	// MSB first with a separator between bits
	task automatic send_packet(input packet_t p);
		for (int i = 3; i >= 0; i--) begin
			if (i != 3)
				send_symbol(1'b1, 1'b1);
			send_symbol(~p[i], p[i]);
		end
		bin1 = 1'b0;
		bin0 = 1'b0;
	endtask

	task automatic expect_packet(input packet_t p);
		sent_q.push_back(p);
		sent_total++;
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		while (!pkt_valid && n < 20) begin
			step();
			n++;
		end
		if (!pkt_valid)
			fail_run("pkt_valid did not rise after a complete packet");
	endtask

	task automatic wait_checked();
		int n;
		n = 0;
		while (checked_count != sent_total && n < 20) begin
			step();
			n++;
		end
		if (checked_count != sent_total)
			fail_run("Queue views were not compared after a packet");
	endtask

	task automatic run_packet(input packet_t p);
		hold_start(`ROUTER_START_HOLD);
		expect_packet(p);
		send_packet(p);
		wait_valid();
		check("armed after packet", 32'd0, 32'(armed));
		wait_checked();
	endtask

	// Compare process that advances the model on every pkt_valid
	always begin
		@(posedge clk);
		#1;
		if (!reset && pkt_valid) begin
			if (sent_q.size() == 0) begin
				fail_run("pkt_valid rose although no packet was sent");
			end else begin
				exp_pkt = sent_q.pop_front();
				check("pkt", 32'(exp_pkt), 32'(pkt));
				model = apply_packet(model, exp_pkt);
				idle(3);	// Drop counts settle two edges later
				compare_model();
				checked_count++;
			end
		end
	end

	initial begin
		reset         = 1'b1;
		start         = 1'b0;
		bin0          = 1'b0;
		bin1          = 1'b0;
		seed          = 32'h9665;
		sent_total    = 0;
		checked_count = 0;
		test_name     = "reset";
		apply_reset();
		check("armed", 32'd0, 32'(armed));
		check("pkt_valid", 32'd0, 32'(pkt_valid));
		compare_model();

		test_name = "short_start";
		hold_start(2);
		step();
		check("armed", 32'd0, 32'(armed));
		hold_start(2);	// Second short run must not add to the first
		step();
		check("armed", 32'd0, 32'(armed));
		send_packet(4'b1101);	// Ignored while unarmed
		idle(4);
		check("armed", 32'd0, 32'(armed));
		hold_start(`ROUTER_START_HOLD);
		check("armed", 32'd1, 32'(armed));

		test_name = "symbol_rules";
		expect_packet(4'b1011);
		send_symbol(1'b0, 1'b1);
		send_symbol(1'b0, 1'b1);	// Repeat without separator
		send_symbol(1'b0, 1'b0);
		send_symbol(1'b1, 1'b1);
		send_symbol(1'b0, 1'b0);
		send_symbol(1'b1, 1'b0);
		send_symbol(1'b1, 1'b0);
		send_symbol(1'b1, 1'b1);
		send_symbol(1'b1, 1'b1);
		send_symbol(1'b0, 1'b1);
		send_symbol(1'b1, 1'b1);
		send_symbol(1'b0, 1'b0);
		send_symbol(1'b0, 1'b1);
		bin1 = 1'b0;
		bin0 = 1'b0;
		wait_valid();
		check("armed after packet", 32'd0, 32'(armed));
		wait_checked();

		test_name = "routing";
		for (int r = 0; r < 2; r++) begin
			for (int d = 0; d < `ROUTER_QUEUES; d++)
				run_packet({2'(d), 2'(d + 2 * r)});
		end

		test_name = "overflow";
		apply_reset();
		for (int i = 0; i < 7; i++)
			run_packet({2'd1, 2'(i)});
		check("queue 1 drops", 32'd1, 32'(queues[1].drops));
		check("drop_total", 32'd1, 32'(drop_total));

		test_name = "random";
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			run_packet(packet_t'(rnd[3:0]));
		end

		if (sent_q.size() == 0 && checked_count == TOTAL_PACKETS) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			fail_run("Packet count at the end does not match the packets sent");
		end
	end

endmodule

// ==== sources.f ====
+incdir+include
source/router_pkg.sv
source/symbol_receiver.sv
source/slot_buffer.sv
source/queue_bank.sv
source/drop_stats.sv
source/packet_router_top.sv
tb/tb_packet_router.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the packet router testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f \
	--top-module tb_packet_router -o sim_packet_router; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_packet_router 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi
